// ==== design/retire_pkg.sv ====
`default_nettype none

package retire_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t; // only bits 3:0 select an rv32e register.
  typedef logic [11:0] csr_addr_t;

  // machine csr addresses.
  localparam csr_addr_t csr_mstatus = 12'h300;
  localparam csr_addr_t csr_mtvec = 12'h305;
  localparam csr_addr_t csr_mepc = 12'h341;
  localparam csr_addr_t csr_mcause = 12'h342;
  localparam csr_addr_t csr_mvendorid = 12'hF11;
  localparam csr_addr_t csr_marchid = 12'hF12;

  localparam word_t mstatus_reset = 32'h0000_1800; // mpp = machine.
  localparam word_t mvendorid_value = 32'h7973_7978;
  localparam word_t marchid_value = 32'h017D_9F58;

  // mcause exception codes.
  localparam word_t cause_inst_misaligned = 32'd0;
  localparam word_t cause_load_misaligned = 32'd4;
  localparam word_t cause_store_misaligned = 32'd6;
  localparam word_t cause_ecall_m = 32'd11;

  localparam int num_gprs = 16;

  // flags reported by the retiring instruction.
  typedef struct packed {
    logic inst_addr_misaligned;
    logic ecall;
    logic mret;
    logic fence_i;
    logic load_addr_misaligned;
    logic store_addr_misaligned;
    logic wrong_prediction;
  } retire_events_t;

endpackage

`default_nettype wire

// ==== design/retire_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface retire_if
  import retire_pkg::*;
();

  logic valid; // load/store stage has an instruction retiring.
  word_t pc;
  word_t next_pc; // from execute.
  retire_events_t events;

  // register write.
  reg_idx_t rd;
  logic wen;
  word_t wdata;

  // csr write.
  csr_addr_t csr_addr;
  logic csr_wen;
  word_t csr_wdata;

  modport gpr_side (input rd, wen, wdata);
  modport csr_side (input pc, csr_addr, csr_wen, csr_wdata);
  modport redirect_side (input valid, next_pc, events);

endinterface

`default_nettype wire

// ==== design/gpr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpr_file
  import retire_pkg::*;
(
  input logic clock,
  input logic reset,
  input reg_idx_t rs1,
  input reg_idx_t rs2,
  input logic commit_enable,
  retire_if.gpr_side port,
  output word_t src1,
  output word_t src2
);

  word_t regs [num_gprs];
  logic [$clog2(num_gprs)-1:0] wr_idx;

  assign wr_idx = port.rd[$clog2(num_gprs)-1:0];

  // x0 is never written, so it keeps its reset zero.
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_gprs; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_enable && port.wen && wr_idx != '0) begin
      regs[wr_idx] <= port.wdata;
    end
  end

  assign src1 = regs[rs1[$clog2(num_gprs)-1:0]];
  assign src2 = regs[rs2[$clog2(num_gprs)-1:0]];

  // decode must never hand rv32e a register above x15.
  rd_in_range: assert property (
    @(posedge clock) disable iff (reset) !(port.wen && port.rd[4])
  );

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file
  import retire_pkg::*;
(
  input logic clock,
  input logic reset,
  input csr_addr_t csr_raddr,
  input logic commit_enable,
  input logic take_trap,
  input word_t trap_cause,
  retire_if.csr_side port,
  output word_t csr_rdata,
  output word_t mtvec_value,
  output word_t mepc_value
);

  word_t mstatus;
  word_t mtvec;
  word_t mepc;
  word_t mcause;

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= mstatus_reset;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else if (commit_enable) begin
      if (take_trap) begin
        // trap capture wins over the instruction's own csr write.
        mcause <= trap_cause;
        mepc <= port.pc;
      end else if (port.csr_wen) begin
        case (port.csr_addr)
          csr_mstatus: mstatus <= port.csr_wdata;
          csr_mtvec: mtvec <= port.csr_wdata;
          csr_mepc: mepc <= port.csr_wdata;
          default: ; // mcause and ids are not writable.
        endcase
      end
    end
  end

  always_comb begin
    case (csr_raddr)
      csr_mstatus: csr_rdata = mstatus;
      csr_mtvec: csr_rdata = mtvec;
      csr_mepc: csr_rdata = mepc;
      csr_mcause: csr_rdata = mcause;
      csr_mvendorid: csr_rdata = mvendorid_value;
      csr_marchid: csr_rdata = marchid_value;
      default: csr_rdata = '0;
    endcase
  end

  assign mtvec_value = mtvec;
  assign mepc_value = mepc;

  // a trap raised in a flush cycle would be lost here.
  trap_only_when_committing: assert property (
    @(posedge clock) disable iff (reset) take_trap |-> commit_enable
  );

endmodule

`default_nettype wire

// ==== design/trap_redirect.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_redirect
  import retire_pkg::*;
(
  input logic clock,
  input logic reset,
  retire_if.redirect_side port,
  input word_t mtvec_value,
  input word_t mepc_value,
  output logic commit_enable,
  output logic take_trap,
  output word_t trap_cause,
  output logic clear_pipeline,
  output logic clear_cache,
  output logic npc_valid,
  output word_t npc
);

  logic exception;
  logic redirect;

  assign exception = port.events.inst_addr_misaligned | port.events.ecall |
                     port.events.load_addr_misaligned | port.events.store_addr_misaligned;

  assign redirect = exception | port.events.mret | port.events.fence_i |
                    port.events.wrong_prediction;

  // the flush cycle squashes whatever sits at retire.
  assign commit_enable = !clear_pipeline;
  assign take_trap = commit_enable && exception;

  // fixed priority, highest first.
  always_comb begin
    if (port.events.inst_addr_misaligned) begin
      trap_cause = cause_inst_misaligned;
    end else if (port.events.ecall) begin
      trap_cause = cause_ecall_m;
    end else if (port.events.load_addr_misaligned) begin
      trap_cause = cause_load_misaligned;
    end else begin
      trap_cause = cause_store_misaligned;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      clear_pipeline <= 1'b0;
      clear_cache <= 1'b0;
      npc_valid <= 1'b0;
      npc <= '0;
    end else if (clear_pipeline) begin
      clear_pipeline <= 1'b0;
      clear_cache <= 1'b0;
      npc_valid <= 1'b0; // npc holds.
    end else begin
      clear_pipeline <= redirect;
      clear_cache <= port.events.fence_i && !exception;
      npc_valid <= port.valid;
      if (exception) begin
        npc <= mtvec_value;
      end else if (port.events.mret) begin
        npc <= mepc_value;
      end else begin
        npc <= port.next_pc;
      end
    end
  end

  flush_is_single_cycle: assert property (
    @(posedge clock) disable iff (reset) clear_pipeline |=> !clear_pipeline
  );

  cache_flush_with_pipeline_flush: assert property (
    @(posedge clock) disable iff (reset) clear_cache |-> clear_pipeline
  );

endmodule

`default_nettype wire

// ==== design/retire_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_unit
  import retire_pkg::*;
(
  input logic clock,
  input logic reset,
  input reg_idx_t rs1,
  input reg_idx_t rs2,
  input reg_idx_t rd,
  input logic wen,
  input word_t wdata,
  input csr_addr_t csr_s,
  input csr_addr_t csr_d,
  input logic csr_wen,
  input word_t csr_wdata,
  input logic ls_valid,
  input retire_events_t events,
  input word_t lsu_pc,
  input word_t exu_npc,
  output word_t src1,
  output word_t src2,
  output word_t csr_src,
  output logic clear_pipeline,
  output logic clear_cache,
  output logic npc_valid,
  output word_t npc
);

  logic commit_enable;
  logic take_trap;
  word_t trap_cause;
  word_t mtvec_value;
  word_t mepc_value;

  retire_if rif ();

  // retire bundle.
  assign rif.valid = ls_valid;
  assign rif.pc = lsu_pc;
  assign rif.next_pc = exu_npc;
  assign rif.events = events;
  assign rif.rd = rd;
  assign rif.wen = wen;
  assign rif.wdata = wdata;
  assign rif.csr_addr = csr_d;
  assign rif.csr_wen = csr_wen;
  assign rif.csr_wdata = csr_wdata;

  gpr_file u_gpr (
    .clock, .reset, .rs1, .rs2, .commit_enable,
    .port(rif.gpr_side), .src1, .src2
  );

  csr_file u_csr (
    .clock, .reset, .csr_raddr(csr_s), .commit_enable, .take_trap, .trap_cause,
    .port(rif.csr_side), .csr_rdata(csr_src), .mtvec_value, .mepc_value
  );

  trap_redirect u_redirect (
    .clock, .reset, .port(rif.redirect_side), .mtvec_value, .mepc_value,
    .commit_enable, .take_trap, .trap_cause,
    .clear_pipeline, .clear_cache, .npc_valid, .npc
  );

endmodule

`default_nettype wire

// ==== sim/retire_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_unit_tb
  import retire_pkg::*;
();

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic wen;
    word_t wdata;
    csr_addr_t csr_s;
    csr_addr_t csr_d;
    logic csr_wen;
    word_t csr_wdata;
    logic ls_valid;
    retire_events_t events;
    word_t lsu_pc;
    word_t exu_npc;
  } stim_t;

  // event bits in struct order (iam, ecall, mret, fence_i, load, store, wrong_prediction).
  localparam logic [6:0] e_none = 7'b0000000;
  localparam logic [6:0] e_iam = 7'b1000000;
  localparam logic [6:0] e_ecall = 7'b0100000;
  localparam logic [6:0] e_mret = 7'b0010000;
  localparam logic [6:0] e_fence = 7'b0001000;
  localparam logic [6:0] e_load = 7'b0000100;
  localparam logic [6:0] e_store = 7'b0000010;
  localparam logic [6:0] e_wp = 7'b0000001;
  localparam csr_addr_t csr_unknown = 12'h7C0;

  logic clock, reset;
  reg_idx_t rs1, rs2, rd;
  logic wen, csr_wen, ls_valid;
  word_t wdata, csr_wdata, lsu_pc, exu_npc;
  csr_addr_t csr_s, csr_d;
  retire_events_t events;
  word_t src1, src2, csr_src, npc;
  logic clear_pipeline, clear_cache, npc_valid;

  stim_t steps [$];
  string names [$];
  stim_t applied;
  logic [31:0] rng = 32'hece4;
  int pass_count = 0;
  int fail_count = 0;
  int step_errors;

  // reference state.
  word_t m_regs [num_gprs];
  word_t m_mstatus, m_mtvec, m_mepc, m_mcause, m_npc;
  logic m_flush, m_cache, m_nvalid;

  retire_unit DUT (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_step(input string name, input reg_idx_t r1, input reg_idx_t r2,
                          input reg_idx_t wr, input logic we, input csr_addr_t cs,
                          input csr_addr_t cd, input logic cwe, input logic valid,
                          input logic [6:0] ev);
    stim_t s;
    s = '0;
    s.rs1 = r1;
    s.rs2 = r2;
    s.rd = wr;
    s.wen = we;
    s.csr_s = cs;
    s.csr_d = cd;
    s.csr_wen = cwe;
    s.ls_valid = valid;
    s.events = retire_events_t'(ev);
    rng = xorshift(rng);
    s.wdata = rng;
    rng = xorshift(rng);
    s.csr_wdata = rng;
    rng = xorshift(rng);
    s.lsu_pc = rng;
    rng = xorshift(rng);
    s.exu_npc = rng;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic apply_inputs(input stim_t s);
    rs1 = s.rs1;
    rs2 = s.rs2;
    rd = s.rd;
    wen = s.wen;
    wdata = s.wdata;
    csr_s = s.csr_s;
    csr_d = s.csr_d;
    csr_wen = s.csr_wen;
    csr_wdata = s.csr_wdata;
    ls_valid = s.ls_valid;
    events = s.events;
    lsu_pc = s.lsu_pc;
    exu_npc = s.exu_npc;
  endtask

  function automatic word_t expected_cause(input retire_events_t e);
    if (e.inst_addr_misaligned) return cause_inst_misaligned;
    if (e.ecall) return cause_ecall_m;
    if (e.load_addr_misaligned) return cause_load_misaligned;
    return cause_store_misaligned;
  endfunction

  function automatic word_t model_csr_read(input csr_addr_t addr);
    case (addr)
      csr_mstatus: return m_mstatus;
      csr_mtvec: return m_mtvec;
      csr_mepc: return m_mepc;
      csr_mcause: return m_mcause;
      csr_mvendorid: return mvendorid_value;
      csr_marchid: return marchid_value;
      default: return '0;
    endcase
  endfunction

  // one clock edge of the retire stage, seen from the inputs held before it.
  task automatic model_update(input stim_t s);
    logic exc;
    exc = s.events.inst_addr_misaligned | s.events.ecall |
          s.events.load_addr_misaligned | s.events.store_addr_misaligned;
    if (m_flush) begin
      m_flush = 1'b0;
      m_cache = 1'b0;
      m_nvalid = 1'b0;
    end else begin
      if (exc) begin
        m_npc = m_mtvec;
      end else if (s.events.mret) begin
        m_npc = m_mepc;
      end else begin
        m_npc = s.exu_npc;
      end
      if (s.wen && s.rd[3:0] != 4'd0) m_regs[s.rd[3:0]] = s.wdata;
      if (exc) begin
        m_mcause = expected_cause(s.events);
        m_mepc = s.lsu_pc;
      end else if (s.csr_wen) begin
        if (s.csr_d == csr_mstatus) m_mstatus = s.csr_wdata;
        if (s.csr_d == csr_mtvec) m_mtvec = s.csr_wdata;
        if (s.csr_d == csr_mepc) m_mepc = s.csr_wdata;
      end
      m_flush = exc | s.events.mret | s.events.fence_i | s.events.wrong_prediction;
      m_cache = s.events.fence_i & !exc;
      m_nvalid = s.ls_valid;
    end
  endtask

  task automatic check_word(input string name, input string what, input word_t exp,
                            input word_t act);
    if (act !== exp) begin
      $display("Fail %s %s expected %h actual %h", name, what, exp, act);
      step_errors++;
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("Fail %s %s expected %b actual %b", name, what, exp, act);
      step_errors++;
    end
  endtask

  initial begin
    #1;
    #((steps.size() + 20) * 100);
    $display("run timed out before the vector table finished");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    for (int i = 0; i < num_gprs; i++) m_regs[i] = '0;
    m_mstatus = mstatus_reset;
    {m_mtvec, m_mepc, m_mcause, m_npc} = '0;
    {m_flush, m_cache, m_nvalid} = '0;
    applied = '0;
    reset = 1'b1;
    apply_inputs('0);
    // name, rs1, rs2, rd, wen, csr_s, csr_d, csr_wen, ls_valid, events.
    add_step("rd_mstatus", 0, 0, 0, 0, csr_mstatus, 0, 0, 0, e_none);
    add_step("rd_mvendorid", 0, 0, 1, 1, csr_mvendorid, 0, 0, 0, e_none);
    add_step("rd_marchid", 1, 1, 2, 1, csr_marchid, 0, 0, 0, e_none);
    add_step("wr_x15", 2, 1, 15, 1, csr_mstatus, 0, 0, 0, e_none);
    add_step("wr_x0", 15, 2, 0, 1, csr_mstatus, 0, 0, 0, e_none);
    add_step("x0_no_wen", 0, 15, 0, 0, csr_mstatus, 0, 0, 0, e_none);
    add_step("wr_mstatus", 0, 0, 15, 0, csr_mstatus, csr_mstatus, 1, 0, e_none);
    add_step("wr_mtvec", 1, 15, 0, 0, csr_mstatus, csr_mtvec, 1, 0, e_none);
    add_step("wr_mepc", 0, 0, 0, 0, csr_mtvec, csr_mepc, 1, 0, e_none);
    add_step("wr_mcause", 0, 0, 0, 0, csr_mepc, csr_mcause, 1, 0, e_none);
    add_step("wr_mvendorid", 0, 0, 0, 0, csr_mcause, csr_mvendorid, 1, 0, e_none);
    add_step("wr_unknown", 0, 0, 0, 0, csr_mvendorid, csr_unknown, 1, 0, e_none);
    add_step("rd_unknown", 0, 0, 0, 0, csr_unknown, 0, 0, 1, e_none);
    add_step("trap_ecall", 0, 0, 3, 1, csr_mcause, csr_mtvec, 1, 1, e_ecall);
    add_step("ecall_flush", 3, 0, 4, 1, csr_mcause, csr_mtvec, 1, 1, e_none);
    add_step("drop_check", 4, 3, 0, 0, csr_mtvec, 0, 0, 0, e_none);
    add_step("trap_all", 0, 0, 0, 0, csr_mepc, 0, 0, 1, e_iam | e_ecall | e_load | e_store);
    add_step("all_flush", 0, 0, 0, 0, csr_mcause, 0, 0, 0, e_none);
    add_step("trap_load", 0, 0, 0, 0, csr_mepc, 0, 0, 1, e_load | e_store);
    add_step("load_flush", 0, 0, 0, 0, csr_mcause, 0, 0, 0, e_none);
    add_step("trap_store", 0, 0, 0, 0, csr_mepc, 0, 0, 1, e_store);
    add_step("store_flush", 0, 0, 0, 0, csr_mcause, 0, 0, 0, e_none);
    add_step("trap_ecall_load", 0, 0, 0, 0, csr_mepc, 0, 0, 1, e_ecall | e_load);
    add_step("ecall_load_flush", 0, 0, 0, 0, csr_mcause, 0, 0, 0, e_none);
    add_step("wr_mepc_again", 0, 0, 0, 0, csr_mepc, csr_mepc, 1, 0, e_none);
    add_step("mret", 0, 0, 0, 0, csr_mepc, 0, 0, 1, e_mret);
    add_step("mret_flush", 0, 0, 0, 0, csr_mepc, 0, 0, 0, e_none);
    add_step("fence_i", 0, 0, 0, 0, csr_mstatus, 0, 0, 1, e_fence);
    add_step("fence_flush", 0, 0, 0, 0, csr_mstatus, 0, 0, 0, e_none);
    add_step("fence_trap", 0, 0, 0, 0, csr_mcause, 0, 0, 1, e_fence | e_ecall);
    add_step("fence_trap_flush", 0, 0, 0, 0, csr_mcause, 0, 0, 0, e_none);
    add_step("mispredict", 0, 0, 0, 0, csr_mtvec, 0, 0, 1, e_wp);
    add_step("mispredict_flush", 0, 0, 0, 0, csr_mtvec, 0, 0, 1, e_none);
    add_step("valid_after_flush", 0, 0, 0, 0, csr_mtvec, 0, 0, 1, e_none);
    add_step("idle_invalid", 0, 0, 0, 0, csr_mtvec, 0, 0, 0, e_none);
    add_step("idle_end", 0, 0, 0, 0, csr_mtvec, 0, 0, 0, e_none);
    repeat (5) @(posedge clock);
    #5 reset = 1'b0;
    for (int i = 0; i < steps.size(); i++) begin
      @(posedge clock);
      model_update(applied);
      #5;
      apply_inputs(steps[i]);
      applied = steps[i];
      #20;
      step_errors = 0;
      check_word(names[i], "src1", m_regs[steps[i].rs1[3:0]], src1);
      check_word(names[i], "src2", m_regs[steps[i].rs2[3:0]], src2);
      check_word(names[i], "csr_src", model_csr_read(steps[i].csr_s), csr_src);
      check_word(names[i], "npc", m_npc, npc);
      check_flag(names[i], "clear_pipeline", m_flush, clear_pipeline);
      check_flag(names[i], "clear_cache", m_cache, clear_cache);
      check_flag(names[i], "npc_valid", m_nvalid, npc_valid);
      if (step_errors == 0) pass_count++;
      else fail_count++;
      $display("step %0d %s: %s", i, names[i], step_errors == 0 ? "ok" : "mismatch");
    end
    $display("%0d steps passed, %0d steps failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/retire_pkg.sv
design/retire_if.sv
design/gpr_file.sv
design/csr_file.sv
design/trap_redirect.sv
design/retire_unit.sv
sim/retire_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the retire unit testbench.

VERILATOR ?= verilator
TOP ?= retire_unit_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result; the run status alone is not trusted.
run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
